//--- Bender.yml
package:
  name: memCtrl

sources:
  - target: rtl
    files:
      - hw/memBusPkg.sv
      - hw/memCtrlPkg.sv
      - hw/memArbFsm.sv
      - hw/byteCounter.sv
      - hw/addrSequencer.sv
      - hw/loadAssembler.sv
      - hw/memCtrl.sv
  - target: dv
    files:
      - dv/ramModel.sv
      - dv/memCtrlTb.sv

//--- build.f
hw/memBusPkg.sv
hw/memCtrlPkg.sv
hw/memArbFsm.sv
hw/byteCounter.sv
hw/addrSequencer.sv
hw/loadAssembler.sv
hw/memCtrl.sv
dv/ramModel.sv
dv/memCtrlTb.sv

//--- dv/memCtrlTb.sv
`timescale 1ns/10ps

module memCtrlTb
    import memBusPkg::*;
    import memCtrlPkg::*;
();

    typedef enum logic [1:0] {opFetch, opLoad, opStore, opBoth} opKind;

    typedef struct packed {
        opKind  port;
        memAddr addr;
        byteLen len;
        memWord wdata;
        logic   stall;
    } stimRow;

    localparam int numRows = 17;
    localparam int watchdogCycles = numRows * 5 * 4 + 50;

    // for opBoth the load uses addr and the fetch uses addr + 'h40
    stimRow stim [numRows] = '{
        '{opFetch, 17'h00100, 3'd4, 32'h0000_0000, 1'b0},
        '{opLoad,  17'h00203, 3'd1, 32'h0000_0000, 1'b0},
        '{opLoad,  17'h00206, 3'd2, 32'h0000_0000, 1'b0},
        '{opLoad,  17'h1fffc, 3'd4, 32'h0000_0000, 1'b0},
        '{opStore, 17'h00300, 3'd4, 32'hdead_beef, 1'b0},
        '{opLoad,  17'h00300, 3'd4, 32'h0000_0000, 1'b0},
        '{opStore, 17'h00305, 3'd1, 32'h0000_00a5, 1'b0},
        '{opStore, 17'h00306, 3'd2, 32'h0000_c3e1, 1'b0},
        '{opLoad,  17'h00304, 3'd4, 32'h0000_0000, 1'b0},
        '{opBoth,  17'h00300, 3'd4, 32'h0000_0000, 1'b0},
        '{opFetch, 17'h01234, 3'd4, 32'h0000_0000, 1'b1},
        '{opLoad,  17'h0abcd, 3'd2, 32'h0000_0000, 1'b1},
        '{opStore, 17'h00400, 3'd4, 32'h1234_5678, 1'b1},
        '{opLoad,  17'h00400, 3'd4, 32'h0000_0000, 1'b1},
        '{opBoth,  17'h00500, 3'd2, 32'h0000_0000, 1'b1},
        '{opStore, 17'h00402, 3'd2, 32'h0000_beef, 1'b1},
        '{opLoad,  17'h00400, 3'd4, 32'h0000_0000, 1'b0}
    };

    logic    clk;
    logic    rst;
    logic    rdy;
    logic    ioBufferFull;
    fetchReq fetchIn;
    fetchRsp fetchResp;
    dataReq  dataIn;
    dataRsp  dataResp;
    ramBus   ramSide;
    memByte  ramRdata;

    memByte      shadow [0:(1 << addrW) - 1];
    memAddr      writeAddr [$];
    memByte      writeData [$];
    logic        stallOn;
    logic [31:0] lfsr = 32'h42a1_7fbc;
    logic [3:0]  stallBits;
    int          mismatches;
    int          failures;

    memCtrl i_dut (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .fetch        (fetchIn),
        .fetchOut     (fetchResp),
        .data         (dataIn),
        .dataOut      (dataResp),
        .ram          (ramSide),
        .ramRdata     (ramRdata)
    );

    ramModel i_ram (
        .clk   (clk),
        .ram   (ramSide),
        .rdata (ramRdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // address folded so every bit shows up in the pattern
    function automatic memByte fillByte(input memAddr a);
        logic [23:0] x;
        x = 24'(a);
        return x[7:0] ^ x[15:8] ^ x[23:16] ^ 8'h5a;
    endfunction

    function automatic memWord expectWord(input memAddr a, input byteLen n);
        memWord w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w[byteW*i +: byteW] = shadow[memAddr'(a + i)];
        end
        return w;
    endfunction

    task automatic reportFailure(input string what);
        failures++;
        $display("ERROR: %s", what);
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            mismatches++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic checkIdle();
        assert (!fetchResp.done && !dataResp.done) else begin
            reportFailure("done pulse lasted more than one cycle or came unasked");
        end
    endtask

    task automatic printCounts();
        $display("%0d mismatches, %0d other failures over %0d rows",
                 mismatches, failures, numRows);
    endtask

    // roughly one stall cycle in four on each input
    always @(posedge clk) begin
        if (stallOn) begin
            for (int b = 0; b < 4; b++) begin
                lfsr = lfsrNext(lfsr);
                stallBits[b] = lfsr[0];
            end
            rdy          <= !(stallBits[0] && stallBits[1]);
            ioBufferFull <= stallBits[2] && stallBits[3];
        end else begin
            rdy          <= 1'b1;
            ioBufferFull <= 1'b0;
        end
    end

    always @(negedge clk) begin
        if (!rst && ramSide.we) begin
            assert (rdy && !ioBufferFull) else begin
                reportFailure("RAM write while rdy was low or the IO buffer was full");
            end
            writeAddr.push_back(ramSide.addr);
            writeData.push_back(ramSide.wdata);
        end
    end

    // counts cycles from the request cycle, drops valid right after each done
    task automatic awaitDone(input logic wantFetch, input logic wantData,
                             output int fetchAt, output int dataAt,
                             output memWord inst, output memWord rdata);
        int   cycle;
        logic fetchSeen;
        logic dataSeen;
        cycle     = 0;
        fetchSeen = !wantFetch;
        dataSeen  = !wantData;
        fetchAt   = -1;
        dataAt    = -1;
        inst      = '0;
        rdata     = '0;
        while (!(fetchSeen && dataSeen)) begin
            @(negedge clk);
            if (fetchResp.done) begin
                assert (!fetchSeen) else begin
                    reportFailure("fetchDone pulsed without a pending fetch");
                end
                if (!fetchSeen) begin
                    fetchSeen = 1'b1;
                    fetchAt   = cycle;
                    inst      = fetchResp.inst;
                end
            end
            if (dataResp.done) begin
                assert (!dataSeen) else begin
                    reportFailure("dataDone pulsed without a pending data request");
                end
                if (!dataSeen) begin
                    dataSeen = 1'b1;
                    dataAt   = cycle;
                    rdata    = dataResp.rdata;
                end
            end
            cycle++;
            @(posedge clk);
            if (fetchSeen) begin
                fetchIn.valid <= 1'b0;
            end
            if (dataSeen) begin
                dataIn.valid <= 1'b0;
            end
        end
    endtask

    task automatic checkStore(input stimRow r);
        memAddr a;
        checkValue("ram.we cycles", writeAddr.size(), r.len);
        for (int i = 0; i < r.len && i < writeAddr.size(); i++) begin
            checkValue("ram.addr", writeAddr[i], memAddr'(r.addr + i));
            checkValue("ram.wdata", writeData[i], r.wdata[byteW*i +: byteW]);
        end
        for (int i = 0; i < r.len; i++) begin
            shadow[memAddr'(r.addr + i)] = r.wdata[byteW*i +: byteW];
        end
        // last write lands at the edge after done
        @(negedge clk);
        checkIdle();
        for (int i = 0; i < r.len; i++) begin
            a = memAddr'(r.addr + i);
            checkValue("backdoor byte", i_ram.peekByte(a), shadow[a]);
        end
    endtask

    task automatic runRow(input stimRow r);
        int     fetchAt;
        int     dataAt;
        memWord inst;
        memWord rdata;
        memAddr fetchAddr;
        logic   wantFetch;
        logic   wantData;
        wantFetch = (r.port == opFetch) || (r.port == opBoth);
        wantData  = (r.port != opFetch);
        fetchAddr = (r.port == opBoth) ? memAddr'(r.addr + 'h40) : r.addr;
        @(negedge clk);
        checkIdle();
        stallOn = r.stall;
        @(posedge clk);
        writeAddr.delete();
        writeData.delete();
        if (wantFetch) begin
            fetchIn <= '{valid: 1'b1, addr: fetchAddr};
        end
        if (wantData) begin
            dataIn <= '{valid: 1'b1, isStore: (r.port == opStore), len: r.len,
                        addr: r.addr, wdata: r.wdata};
        end
        awaitDone(wantFetch, wantData, fetchAt, dataAt, inst, rdata);
        if (wantFetch) begin
            checkValue("fetchOut.inst", inst, expectWord(fetchAddr, byteLen'(fetchLen)));
        end
        if (wantData && r.port != opStore) begin
            checkValue("dataOut.rdata", rdata, expectWord(r.addr, r.len));
        end
        if (r.port == opBoth) begin
            assert (dataAt < fetchAt) else begin
                reportFailure("fetch finished before the data request");
            end
        end
        if (!r.stall) begin
            if (wantData) begin
                checkValue("dataDone latency", dataAt,
                           (r.port == opStore) ? r.len : r.len + 1);
            end
            if (wantFetch) begin
                checkValue("fetchDone latency", fetchAt, (r.port == opBoth) ? r.len + 7 : 5);
            end
        end
        if (r.port == opStore) begin
            checkStore(r);
        end else begin
            checkValue("ram.we cycles", writeAddr.size(), 0);
        end
    endtask

    initial begin
        rst          = 1'b1;
        rdy          = 1'b1;
        ioBufferFull = 1'b0;
        fetchIn      = '0;
        dataIn       = '0;
        stallOn      = 1'b0;
        mismatches   = 0;
        failures     = 0;
        for (int a = 0; a < (1 << addrW); a++) begin
            shadow[a] = fillByte(memAddr'(a));
            i_ram.pokeByte(memAddr'(a), shadow[a]);
        end
        // reset for 8 edges, last check is the first cycle out of reset
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            if (i == 7) begin
                rst <= 1'b0;
            end
            @(negedge clk);
            assert (!fetchResp.done && !dataResp.done && !ramSide.we) else begin
                reportFailure("done or RAM write enable high around reset");
            end
        end
        for (int i = 0; i < numRows; i++) begin
            runRow(stim[i]);
        end
        @(negedge clk);
        checkIdle();
        printCounts();
        if (mismatches == 0 && failures == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, a request never completed",
                 watchdogCycles);
        printCounts();
        $display("test failed");
        $finish;
    end

endmodule

//--- dv/ramModel.sv
`timescale 1ns/10ps

module ramModel
    import memBusPkg::*;
    import memCtrlPkg::*;
(
    input  logic   clk,
    input  ramBus  ram,
    output memByte rdata
);

    memByte mem [0:(1 << addrW) - 1];

    // registered read, so the byte shows up one cycle after its address
    always @(posedge clk) begin
        if (ram.we) begin
            mem[ram.addr] <= ram.wdata;
        end
        rdata <= mem[ram.addr];
    end

    // backdoor access for preload and readback
    task automatic pokeByte(input memAddr a, input memByte b);
        mem[a] = b;
    endtask

    function automatic memByte peekByte(input memAddr a);
        return mem[a];
    endfunction

endmodule

//--- hw/addrSequencer.sv
`timescale 1ns/10ps

module addrSequencer
    import memBusPkg::*;
    import memCtrlPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    accept,
    input  logic    issue,
    input  logic    isStore,
    input  fetchReq fetch,
    input  dataReq  data,
    input  byteIdx  issueIdx,
    output ramBus   ram
);

    memAddr baseAddr;
    memWord storeWord;

    always_ff @(posedge clk) begin
        if (rst) begin
            baseAddr <= '0;
        end else if (accept) begin
            // same priority as the arbiter
            baseAddr <= data.valid ? data.addr : fetch.addr;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            storeWord <= data.wdata;
        end
    end

    // little-endian, byte 0 goes to the base address
    assign ram.addr  = baseAddr + memAddr'(issueIdx);
    assign ram.wdata = storeWord[byteW*issueIdx +: byteW];
    assign ram.we    = issue && isStore;

endmodule

//--- hw/byteCounter.sv
`timescale 1ns/10ps

module byteCounter
    import memBusPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   clearCount,
    input  logic   issue,
    input  logic   capture,
    input  byteLen len,
    output byteIdx issueIdx,
    output byteIdx captureIdx,
    output logic   lastIssue,
    output logic   lastCapture
);

    // wide enough to reach 4 after the last byte
    byteLen issueCnt;
    byteLen captureCnt;

    always_ff @(posedge clk) begin
        if (rst || clearCount) begin
            issueCnt   <= '0;
            captureCnt <= '0;
        end else begin
            if (issue) begin
                issueCnt <= issueCnt + byteLen'(1);
            end
            if (capture) begin
                captureCnt <= captureCnt + byteLen'(1);
            end
        end
    end

    assign issueIdx    = issueCnt[1:0];
    assign captureIdx  = captureCnt[1:0];
    assign lastIssue   = (issueCnt == len - byteLen'(1));
    assign lastCapture = (captureCnt == len - byteLen'(1));

    captureBehindIssue: assert property (@(posedge clk) disable iff (rst)
        captureCnt <= issueCnt);

endmodule

//--- hw/loadAssembler.sv
`timescale 1ns/10ps

module loadAssembler
    import memBusPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   clearCount,
    input  logic   capture,
    input  byteIdx captureIdx,
    input  byteLen len,
    input  memByte ramRdata,
    output memWord word
);

    memWord lanes;

    always_ff @(posedge clk) begin
        if (rst || clearCount) begin
            lanes <= '0;
        end else if (capture) begin
            lanes[byteW*captureIdx +: byteW] <= ramRdata;
        end
    end

    always_comb begin
        word = lanes;
        // final byte bypasses the register so done sees a full word
        if (capture) begin
            word[byteW*captureIdx +: byteW] = ramRdata;
        end
        // zero extend above the transfer length
        for (int i = 0; i < wordW / byteW; i++) begin
            if (i >= len) begin
                word[byteW*i +: byteW] = '0;
            end
        end
    end

endmodule

//--- hw/memArbFsm.sv
`timescale 1ns/10ps

module memArbFsm
    import memBusPkg::*;
    import memCtrlPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    rdy,
    input  logic    ioBufferFull,
    input  fetchReq fetch,
    input  dataReq  data,
    input  logic    lastIssue,
    input  logic    lastCapture,
    output logic    accept,
    output logic    issue,
    output logic    capture,
    output logic    isStore,
    output byteLen  selLen,
    output logic    clearCount,
    output logic    fetchDone,
    output logic    dataDone
);

    arbState state;
    arbState stateNext;
    logic    pending;
    logic    readState;
    logic    lastReturn;
    logic    storeEnd;

    assign readState  = (state == stFetch) || (state == stLoad);
    assign isStore    = (state == stStore);
    assign clearCount = (state == stIdle);

    // a read issue always comes back one cycle later, stall or not
    assign capture    = pending;
    assign lastReturn = capture && lastCapture;

    assign accept = (state == stIdle) && rdy && (data.valid || fetch.valid);

    // no issue in the cycle the final byte returns
    always_comb begin
        issue = 1'b0;
        if (readState) begin
            issue = rdy && !lastReturn;
        end else if (isStore) begin
            issue = rdy && !ioBufferFull;
        end
    end

    assign storeEnd = isStore && issue && lastIssue;

    assign selLen = (state == stFetch) ? byteLen'(fetchLen) : data.len;

    always_comb begin
        stateNext = state;
        case (state)
            stIdle: begin
                // data port has priority
                if (accept && data.valid) begin
                    stateNext = data.isStore ? stStore : stLoad;
                end else if (accept) begin
                    stateNext = stFetch;
                end
            end
            stFetch, stLoad: begin
                if (lastReturn) begin
                    stateNext = stIdle;
                end
            end
            stStore: begin
                if (storeEnd) begin
                    stateNext = stIdle;
                end
            end
            default: stateNext = stIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= stIdle;
            pending <= 1'b0;
        end else begin
            state   <= stateNext;
            pending <= issue && readState;
        end
    end

    assign fetchDone = (state == stFetch) && lastReturn;
    assign dataDone  = ((state == stLoad) && lastReturn) || storeEnd;

    doneToRequester: assert property (@(posedge clk) disable iff (rst)
        (!fetchDone || fetch.valid) && (!dataDone || data.valid));

    noCaptureInIdle: assert property (@(posedge clk) disable iff (rst)
        (state == stIdle) |-> !capture);

endmodule

//--- hw/memBusPkg.sv
package memBusPkg;

    // byte-wide RAM with 128 KiB of address space
    localparam int addrW = 17;
    localparam int wordW = 32;
    localparam int byteW = 8;

    // instructions are always a full word
    localparam int fetchLen = 4;

    typedef logic [addrW-1:0] memAddr;
    typedef logic [byteW-1:0] memByte;
    typedef logic [wordW-1:0] memWord;

    // transfer length in bytes, only 1, 2 or 4 are legal
    typedef logic [2:0] byteLen;

    // byte lane within a word
    typedef logic [1:0] byteIdx;

endpackage

//--- hw/memCtrl.sv
`timescale 1ns/10ps

module memCtrl
    import memBusPkg::*;
    import memCtrlPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    rdy,
    input  logic    ioBufferFull,
    input  fetchReq fetch,
    output fetchRsp fetchOut,
    input  dataReq  data,
    output dataRsp  dataOut,
    output ramBus   ram,
    input  memByte  ramRdata
);

    logic   accept;
    logic   issue;
    logic   capture;
    logic   isStore;
    logic   clearCount;
    logic   fetchDone;
    logic   dataDone;
    logic   lastIssue;
    logic   lastCapture;
    byteLen selLen;
    byteIdx issueIdx;
    byteIdx captureIdx;
    memWord word;

    memArbFsm i_arbFsm (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .fetch        (fetch),
        .data         (data),
        .lastIssue    (lastIssue),
        .lastCapture  (lastCapture),
        .accept       (accept),
        .issue        (issue),
        .capture      (capture),
        .isStore      (isStore),
        .selLen       (selLen),
        .clearCount   (clearCount),
        .fetchDone    (fetchDone),
        .dataDone     (dataDone)
    );

    byteCounter i_byteCounter (
        .clk         (clk),
        .rst         (rst),
        .clearCount  (clearCount),
        .issue       (issue),
        .capture     (capture),
        .len         (selLen),
        .issueIdx    (issueIdx),
        .captureIdx  (captureIdx),
        .lastIssue   (lastIssue),
        .lastCapture (lastCapture)
    );

    addrSequencer i_addrSeq (
        .clk      (clk),
        .rst      (rst),
        .accept   (accept),
        .issue    (issue),
        .isStore  (isStore),
        .fetch    (fetch),
        .data     (data),
        .issueIdx (issueIdx),
        .ram      (ram)
    );

    loadAssembler i_loadAsm (
        .clk        (clk),
        .rst        (rst),
        .clearCount (clearCount),
        .capture    (capture),
        .captureIdx (captureIdx),
        .len        (selLen),
        .ramRdata   (ramRdata),
        .word       (word)
    );

    // one assembled word serves both ports, done says whose it is
    assign fetchOut = '{done: fetchDone, inst: word};
    assign dataOut  = '{done: dataDone, rdata: word};

endmodule

//--- hw/memCtrlPkg.sv
package memCtrlPkg;

    import memBusPkg::*;

    typedef enum logic [1:0] {
        stIdle,
        stFetch,
        stLoad,
        stStore
    } arbState;

    // instruction fetch side
    typedef struct packed {
        logic   valid;
        memAddr addr;
    } fetchReq;

    typedef struct packed {
        logic   done;
        memWord inst;
    } fetchRsp;

    // load/store side
    typedef struct packed {
        logic   valid;
        logic   isStore;
        byteLen len;
        memAddr addr;
        memWord wdata;
    } dataReq;

    typedef struct packed {
        logic   done;
        memWord rdata;
    } dataRsp;

    // toward the byte RAM, read data returns one cycle later
    typedef struct packed {
        logic   we;
        memAddr addr;
        memByte wdata;
    } ramBus;

endpackage
